//--- rtl/isa_pkg.sv
// ####################
// MIPS ISA encodings
// ####################
`default_nettype none

package isa_pkg;

   // primary opcode field, inst[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b
   } op_e;

   // function field of special, inst[5:0]
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_SYSCALL = 6'h0c,
      FN_ADDU    = 6'h21,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a,
      FN_SLTU    = 6'h2b
   } funct_e;

   // add is zero so a bubble computes a harmless sum
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
      ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_LUI
   } alu_op_e;

   typedef enum logic [1:0] {
      MEM_BYTE,
      MEM_HALF,
      MEM_WORD
   } mem_size_e;

endpackage

`default_nettype wire

//--- rtl/core_pkg.sv
// ####################
// core pipeline types
// ####################
`default_nettype none

package core_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0]   word_t;
   // byte address without the two lane bits
   typedef logic [XLEN-3:0]   word_addr_t;
   typedef logic [4:0]        reg_idx_t;
   typedef logic [XLEN/8-1:0] byte_en_t;

   // decoded control, all zero means bubble
   typedef struct packed {
      isa_pkg::alu_op_e   alu_op;
      logic               use_imm;
      logic               reg_we;
      logic               mem_read;
      logic               mem_write;
      isa_pkg::mem_size_e mem_size;
      logic               mem_unsigned;
      logic               syscall;
   } ctrl_t;

   // decode to execute
   typedef struct packed {
      ctrl_t    ctrl;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      logic [4:0] shamt;
      reg_idx_t dest;
   } id_ex_t;

   // execute to memory
   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_res;
      word_t    rt_val;
      reg_idx_t dest;
   } ex_mem_t;

   // memory to writeback, only what the register file and halt need
   typedef struct packed {
      logic     reg_we;
      logic     syscall;
      word_t    result;
      reg_idx_t dest;
   } mem_wb_t;

endpackage

`default_nettype wire

//--- rtl/inst_decode.sv
// ####################
// instruction decoder
// ####################
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
   input  wire core_pkg::word_t inst,
   output core_pkg::ctrl_t      ctrl,
   output core_pkg::word_t      imm
);

   isa_pkg::op_e    op;
   isa_pkg::funct_e funct;
   core_pkg::word_t imm_sext;
   core_pkg::word_t imm_zext;

   assign op       = isa_pkg::op_e'(inst[31:26]);
   assign funct    = isa_pkg::funct_e'(inst[5:0]);
   assign imm_sext = {{16{inst[15]}}, inst[15:0]};
   assign imm_zext = {16'h0000, inst[15:0]};

   always_comb
   begin
      // unknown encodings fall out as a bubble
      ctrl = '0;
      imm  = imm_sext;
      case (op)
         isa_pkg::OP_SPECIAL:
         begin
            ctrl.reg_we = 1'b1;
            case (funct)
               isa_pkg::FN_ADDU: ctrl.alu_op = isa_pkg::ALU_ADD;
               isa_pkg::FN_SUBU: ctrl.alu_op = isa_pkg::ALU_SUB;
               isa_pkg::FN_AND:  ctrl.alu_op = isa_pkg::ALU_AND;
               isa_pkg::FN_OR:   ctrl.alu_op = isa_pkg::ALU_OR;
               isa_pkg::FN_XOR:  ctrl.alu_op = isa_pkg::ALU_XOR;
               isa_pkg::FN_NOR:  ctrl.alu_op = isa_pkg::ALU_NOR;
               isa_pkg::FN_SLT:  ctrl.alu_op = isa_pkg::ALU_SLT;
               isa_pkg::FN_SLTU: ctrl.alu_op = isa_pkg::ALU_SLTU;
               isa_pkg::FN_SLL:  ctrl.alu_op = isa_pkg::ALU_SLL;
               isa_pkg::FN_SRL:  ctrl.alu_op = isa_pkg::ALU_SRL;
               isa_pkg::FN_SRA:  ctrl.alu_op = isa_pkg::ALU_SRA;
               isa_pkg::FN_SLLV: ctrl.alu_op = isa_pkg::ALU_SLLV;
               isa_pkg::FN_SRLV: ctrl.alu_op = isa_pkg::ALU_SRLV;
               isa_pkg::FN_SRAV: ctrl.alu_op = isa_pkg::ALU_SRAV;
               isa_pkg::FN_SYSCALL:
               begin
                  // no register write, only the halt marker travels
                  ctrl.reg_we  = 1'b0;
                  ctrl.syscall = 1'b1;
               end
               default: ctrl.reg_we = 1'b0;
            endcase
         end
         // arithmetic immediates keep the sign extension
         isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU:
         begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
            if (op == isa_pkg::OP_SLTI)
               ctrl.alu_op = isa_pkg::ALU_SLT;
            else if (op == isa_pkg::OP_SLTIU)
               ctrl.alu_op = isa_pkg::ALU_SLTU;
         end
         // logic immediates and lui zero-extend
         isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI:
         begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
            imm          = imm_zext;
            case (op)
               isa_pkg::OP_ANDI: ctrl.alu_op = isa_pkg::ALU_AND;
               isa_pkg::OP_ORI:  ctrl.alu_op = isa_pkg::ALU_OR;
               isa_pkg::OP_XORI: ctrl.alu_op = isa_pkg::ALU_XOR;
               default:          ctrl.alu_op = isa_pkg::ALU_LUI;
            endcase
         end
         // loads, address is rs plus offset
         isa_pkg::OP_LB, isa_pkg::OP_LBU, isa_pkg::OP_LH, isa_pkg::OP_LHU, isa_pkg::OP_LW:
         begin
            ctrl.use_imm      = 1'b1;
            ctrl.reg_we       = 1'b1;
            ctrl.mem_read     = 1'b1;
            ctrl.mem_unsigned = (op == isa_pkg::OP_LBU) || (op == isa_pkg::OP_LHU);
            if (op == isa_pkg::OP_LB || op == isa_pkg::OP_LBU)
               ctrl.mem_size = isa_pkg::MEM_BYTE;
            else if (op == isa_pkg::OP_LH || op == isa_pkg::OP_LHU)
               ctrl.mem_size = isa_pkg::MEM_HALF;
            else
               ctrl.mem_size = isa_pkg::MEM_WORD;
         end
         isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW:
         begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_write = 1'b1;
            if (op == isa_pkg::OP_SB)
               ctrl.mem_size = isa_pkg::MEM_BYTE;
            else if (op == isa_pkg::OP_SH)
               ctrl.mem_size = isa_pkg::MEM_HALF;
            else
               ctrl.mem_size = isa_pkg::MEM_WORD;
         end
         default: ctrl = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// ####################
// register file
// ####################
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  wire                     clk,
   input  wire                     rst_b,
   input  wire core_pkg::reg_idx_t rs_idx,
   input  wire core_pkg::reg_idx_t rt_idx,
   output core_pkg::word_t         rs_data,
   output core_pkg::word_t         rt_data,
   input  wire                     wr_en,
   input  wire core_pkg::reg_idx_t wr_idx,
   input  wire core_pkg::word_t    wr_data
);

   // $zero has no storage
   core_pkg::word_t regs [1:31];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end
      else if (wr_en && wr_idx != '0)
         regs[wr_idx] <= wr_data;
   end

   // write-through so decode sees the writeback value in the same cycle
   assign rs_data = (rs_idx == '0)                 ? '0      :
                    (wr_en && wr_idx == rs_idx)    ? wr_data :
                                                     regs[rs_idx];
   assign rt_data = (rt_idx == '0)                 ? '0      :
                    (wr_en && wr_idx == rt_idx)    ? wr_data :
                                                     regs[rt_idx];

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
// ####################
// RAW stall detect
// ####################
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
   input  wire core_pkg::reg_idx_t rs_idx,
   input  wire core_pkg::reg_idx_t rt_idx,
   input  wire core_pkg::id_ex_t   id_ex,
   input  wire core_pkg::ex_mem_t  ex_mem,
   output logic                    stall
);

   // one source against one producer, $zero never waits
   function automatic logic hit(core_pkg::reg_idx_t src, core_pkg::reg_idx_t dst, logic we);
      return we && (src != '0) && (src == dst);
   endfunction

   // writeback is covered by the register file bypass
   assign stall = hit(rs_idx, id_ex.dest,  id_ex.ctrl.reg_we)  ||
                  hit(rt_idx, id_ex.dest,  id_ex.ctrl.reg_we)  ||
                  hit(rs_idx, ex_mem.dest, ex_mem.ctrl.reg_we) ||
                  hit(rt_idx, ex_mem.dest, ex_mem.ctrl.reg_we);

endmodule

`default_nettype wire

//--- rtl/alu.sv
// ####################
// integer ALU
// ####################
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire isa_pkg::alu_op_e op,
   input  wire core_pkg::word_t  a,
   input  wire core_pkg::word_t  b,
   input  wire [4:0]             shamt,
   output core_pkg::word_t       result
);

   // variable shifts take the amount from rs
   logic [4:0] vshamt;
   logic       lt_s;
   logic       lt_u;

   assign vshamt = a[4:0];
   assign lt_s   = $signed(a) < $signed(b);
   assign lt_u   = a < b;

   always_comb
   begin
      case (op)
         isa_pkg::ALU_ADD:  result = a + b;
         isa_pkg::ALU_SUB:  result = a - b;
         isa_pkg::ALU_AND:  result = a & b;
         isa_pkg::ALU_OR:   result = a | b;
         isa_pkg::ALU_XOR:  result = a ^ b;
         isa_pkg::ALU_NOR:  result = ~(a | b);
         // compares return 0 or 1
         isa_pkg::ALU_SLT:  result = {{(core_pkg::XLEN-1){1'b0}}, lt_s};
         isa_pkg::ALU_SLTU: result = {{(core_pkg::XLEN-1){1'b0}}, lt_u};
         // constant shifts act on rt
         isa_pkg::ALU_SLL:  result = b << shamt;
         isa_pkg::ALU_SRL:  result = b >> shamt;
         isa_pkg::ALU_SRA:  result = $signed(b) >>> shamt;
         isa_pkg::ALU_SLLV: result = b << vshamt;
         isa_pkg::ALU_SRLV: result = b >> vshamt;
         isa_pkg::ALU_SRAV: result = $signed(b) >>> vshamt;
         // immediate already zero-extended by decode
         isa_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
         default:           result = a + b;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/mem_align.sv
// ####################
// load/store lanes
// ####################
`timescale 1ns/1ps
`default_nettype none

module mem_align (
   input  wire core_pkg::ctrl_t  ctrl,
   input  wire [1:0]             byte_off,
   input  wire core_pkg::word_t  store_src,
   input  wire core_pkg::word_t  rdata,
   output core_pkg::word_t       wdata,
   output core_pkg::byte_en_t    we,
   output core_pkg::word_t       load_data
);

   core_pkg::byte_en_t lanes;
   core_pkg::word_t    byte_sel;
   core_pkg::word_t    half_sel;

   // little-endian, lane k is bits 8k+7:8k
   always_comb
   begin
      case (ctrl.mem_size)
         isa_pkg::MEM_BYTE:
         begin
            wdata = {4{store_src[7:0]}};
            lanes = core_pkg::byte_en_t'(4'b0001) << byte_off;
         end
         isa_pkg::MEM_HALF:
         begin
            // halves sit on even offsets
            wdata = {2{store_src[15:0]}};
            lanes = core_pkg::byte_en_t'(4'b0011) << {byte_off[1], 1'b0};
         end
         isa_pkg::MEM_WORD:
         begin
            wdata = store_src;
            lanes = 4'b1111;
         end
         default:
         begin
            wdata = store_src;
            lanes = '0;
         end
      endcase
   end

   assign we = ctrl.mem_write ? lanes : '0;

   // move the addressed byte or half down to bit 0
   assign byte_sel = rdata >> {byte_off, 3'b000};
   assign half_sel = rdata >> {byte_off[1], 4'h0};

   always_comb
   begin
      case (ctrl.mem_size)
         isa_pkg::MEM_BYTE:
            load_data = ctrl.mem_unsigned ? {24'h000000, byte_sel[7:0]}
                                          : {{24{byte_sel[7]}}, byte_sel[7:0]};
         isa_pkg::MEM_HALF:
            load_data = ctrl.mem_unsigned ? {16'h0000, half_sel[15:0]}
                                          : {{16{half_sel[15]}}, half_sel[15:0]};
         default:
            load_data = rdata;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
// ####################
// MIPS 5-stage core
// ####################
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
   parameter core_pkg::word_t TEXT_START = 32'h0040_0000
) (
   input  wire                   clk,
   input  wire                   rst_b,
   output core_pkg::word_addr_t  inst_addr,
   input  wire core_pkg::word_t  inst,
   output core_pkg::word_addr_t  mem_addr,
   output core_pkg::word_t       mem_wdata,
   output core_pkg::byte_en_t    mem_we,
   input  wire core_pkg::word_t  mem_rdata,
   output logic                  halted
);

   // fetch to decode
   typedef struct packed {
      core_pkg::word_t inst;
      logic            valid;
   } if_id_t;

   core_pkg::word_t    pc;
   if_id_t             if_id;
   core_pkg::id_ex_t   id_ex;
   core_pkg::ex_mem_t  ex_mem;
   core_pkg::mem_wb_t  mem_wb;
   // set once a syscall leaves decode
   logic               frozen;

   core_pkg::word_t    id_inst;
   core_pkg::ctrl_t    dec_ctrl;
   core_pkg::ctrl_t    id_ctrl;
   core_pkg::word_t    id_imm;
   core_pkg::word_t    rs_data;
   core_pkg::word_t    rt_data;
   core_pkg::reg_idx_t id_rs;
   core_pkg::reg_idx_t id_rt;
   core_pkg::reg_idx_t id_dest;
   core_pkg::reg_idx_t hz_rt;
   logic               stall;
   logic               freeze;
   core_pkg::word_t    alu_b;
   core_pkg::word_t    alu_res;
   core_pkg::word_t    load_data;

   assign inst_addr = pc[31:2];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc     <= TEXT_START;
         if_id  <= '0;
         frozen <= 1'b0;
      end
      else if (!stall)
      begin
         // a syscall in decode stops fetch for good
         if (freeze)
            if_id.valid <= 1'b0;
         else
         begin
            pc          <= pc + 32'd4;
            if_id.inst  <= inst;
            if_id.valid <= 1'b1;
         end
         frozen <= freeze;
      end
   end

   // an empty decode slot reads as a zero word
   assign id_inst = if_id.valid ? if_id.inst : '0;
   assign id_rs   = id_inst[25:21];
   assign id_rt   = id_inst[20:16];

   inst_decode u_inst_decode (
      .inst (id_inst),
      .ctrl (dec_ctrl),
      .imm  (id_imm)
   );

   assign id_ctrl = if_id.valid ? dec_ctrl : '0;
   assign freeze  = frozen || id_ctrl.syscall;
   // I-type results go to rt, R-type to rd
   assign id_dest = id_ctrl.use_imm ? id_rt : id_inst[15:11];
   // rt is a source only for R-type and stores
   assign hz_rt   = (!id_ctrl.use_imm || id_ctrl.mem_write) ? id_rt : '0;

   reg_file u_reg_file (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (id_rs),
      .rt_idx  (id_rt),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wr_en   (mem_wb.reg_we),
      .wr_idx  (mem_wb.dest),
      .wr_data (mem_wb.result)
   );

   hazard_unit u_hazard_unit (
      .rs_idx (id_rs),
      .rt_idx (hz_rt),
      .id_ex  (id_ex),
      .ex_mem (ex_mem),
      .stall  (stall)
   );

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         id_ex <= '0;
      else if (stall)
         id_ex <= '0;
      else
      begin
         id_ex.ctrl   <= id_ctrl;
         id_ex.rs_val <= rs_data;
         id_ex.rt_val <= rt_data;
         id_ex.imm    <= id_imm;
         id_ex.shamt  <= id_inst[10:6];
         id_ex.dest   <= id_dest;
      end
   end

   assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rt_val;

   alu u_alu (
      .op     (id_ex.ctrl.alu_op),
      .a      (id_ex.rs_val),
      .b      (alu_b),
      .shamt  (id_ex.shamt),
      .result (alu_res)
   );

   // execute, memory and writeback never hold
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         ex_mem <= '0;
         mem_wb <= '0;
         halted <= 1'b0;
      end
      else
      begin
         ex_mem.ctrl    <= id_ex.ctrl;
         ex_mem.alu_res <= alu_res;
         ex_mem.rt_val  <= id_ex.rt_val;
         ex_mem.dest    <= id_ex.dest;
         mem_wb.reg_we  <= ex_mem.ctrl.reg_we;
         mem_wb.syscall <= ex_mem.ctrl.syscall;
         mem_wb.result  <= ex_mem.ctrl.mem_read ? load_data : ex_mem.alu_res;
         mem_wb.dest    <= ex_mem.dest;
         // sticky until reset
         halted         <= halted || mem_wb.syscall;
      end
   end

   assign mem_addr = ex_mem.alu_res[31:2];

   mem_align u_mem_align (
      .ctrl      (ex_mem.ctrl),
      .byte_off  (ex_mem.alu_res[1:0]),
      .store_src (ex_mem.rt_val),
      .rdata     (mem_rdata),
      .wdata     (mem_wdata),
      .we        (mem_we),
      .load_data (load_data)
   );

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
// ####################
// testbench memories
// ####################
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
   parameter int DEPTH = 256
) (
   input  wire                       clk,
   input  wire core_pkg::word_addr_t inst_addr,
   output core_pkg::word_t           inst,
   input  wire core_pkg::word_addr_t mem_addr,
   input  wire core_pkg::word_t      mem_wdata,
   input  wire core_pkg::byte_en_t   mem_we,
   output core_pkg::word_t           mem_rdata
);

   localparam int AW = $clog2(DEPTH);

   // program words, written by the testbench before reset
   core_pkg::word_t rom [0:DEPTH-1];
   core_pkg::word_t ram [0:DEPTH-1];
   logic [AW-1:0]   rom_idx;
   logic [AW-1:0]   ram_idx;

   // both memories wrap on the low word address bits
   assign rom_idx   = inst_addr[AW-1:0];
   assign ram_idx   = mem_addr[AW-1:0];
   assign inst      = rom[rom_idx];
   assign mem_rdata = ram[ram_idx];

   // background pattern, each word carries its own index
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         ram[i] = 32'hc0de_0000 | core_pkg::word_t'(i);
   end

   // byte lanes write independently, lane k is bits 8k+7:8k
   always @(posedge clk)
   begin
      for (int k = 0; k < 4; k++)
      begin
         if (mem_we[k])
            ram[ram_idx][8*k +: 8] <= mem_wdata[8*k +: 8];
      end
   end

endmodule

`default_nettype wire

//--- tests/tb_mips_core.sv
// ####################
// MIPS core testbench
// ####################
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

   localparam core_pkg::word_t TEXT_START = 32'h0040_0000;
   localparam core_pkg::word_t DATA_BASE  = 32'h1001_0000;
   localparam int              ROM_DEPTH  = 256;
   localparam int              MAX_CYCLES = 2000;
   // register roles in the test program
   localparam logic [4:0]      R_A    = 5'd8;
   localparam logic [4:0]      R_B    = 5'd9;
   localparam logic [4:0]      R_D    = 5'd10;
   localparam logic [4:0]      R_SRC  = 5'd11;
   localparam logic [4:0]      R_LD   = 5'd12;
   localparam logic [4:0]      R_BASE = 5'd20;

   logic                 clk;
   logic                 rst_b;
   core_pkg::word_addr_t inst_addr;
   core_pkg::word_t      inst;
   core_pkg::word_addr_t mem_addr;
   core_pkg::word_t      mem_wdata;
   core_pkg::byte_en_t   mem_we;
   core_pkg::word_t      mem_rdata;
   logic                 halted;

   int                   errors = 0;
   int                   checks = 0;
   logic [15:0]          lfsr;
   int                   pc_idx;
   int                   slot;
   logic                 halt_seen = 1'b0;
   core_pkg::word_addr_t halt_iaddr;

   // expected stores in program order
   string                exp_name [$];
   core_pkg::word_addr_t exp_addr [$];
   core_pkg::byte_en_t   exp_we [$];
   core_pkg::word_t      exp_data [$];

   mips_core #(
      .TEXT_START (TEXT_START)
   ) u_mips_core (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst_addr (inst_addr),
      .inst      (inst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .mem_rdata (mem_rdata),
      .halted    (halted)
   );

   tb_mem_model #(
      .DEPTH (ROM_DEPTH)
   ) u_mem (
      .clk       (clk),
      .inst_addr (inst_addr),
      .inst      (inst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we),
      .mem_rdata (mem_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one LFSR step per bit taken
   function automatic core_pkg::word_t rand_bits(int n);
      core_pkg::word_t r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic core_pkg::word_t rtype_word(logic [5:0] funct, logic [4:0] rs,
         logic [4:0] rt, logic [4:0] rd, logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, funct};
   endfunction

   function automatic core_pkg::word_t itype_word(logic [5:0] op, logic [4:0] rs,
         logic [4:0] rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // reference results from the ISA definition, rs is a and rt is b
   function automatic core_pkg::word_t alu_model(logic [5:0] op, logic [5:0] funct,
         core_pkg::word_t a, core_pkg::word_t b, logic [15:0] imm, logic [4:0] sh);
      core_pkg::word_t se;
      core_pkg::word_t ze;
      se = {{16{imm[15]}}, imm};
      ze = {16'h0000, imm};
      case (op)
         isa_pkg::OP_SPECIAL:
            case (funct)
               isa_pkg::FN_ADDU: return a + b;
               isa_pkg::FN_SUBU: return a - b;
               isa_pkg::FN_AND:  return a & b;
               isa_pkg::FN_OR:   return a | b;
               isa_pkg::FN_XOR:  return a ^ b;
               isa_pkg::FN_NOR:  return ~(a | b);
               isa_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               isa_pkg::FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
               isa_pkg::FN_SLL:  return b << sh;
               isa_pkg::FN_SRL:  return b >> sh;
               isa_pkg::FN_SRA:  return $signed(b) >>> sh;
               isa_pkg::FN_SLLV: return b << a[4:0];
               isa_pkg::FN_SRLV: return b >> a[4:0];
               isa_pkg::FN_SRAV: return $signed(b) >>> a[4:0];
               default:          return 'x;
            endcase
         isa_pkg::OP_ADDIU: return a + se;
         isa_pkg::OP_SLTI:  return ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
         // sltiu compares against the sign-extended immediate as unsigned
         isa_pkg::OP_SLTIU: return (a < se) ? 32'd1 : 32'd0;
         isa_pkg::OP_ANDI:  return a & ze;
         isa_pkg::OP_ORI:   return a | ze;
         isa_pkg::OP_XORI:  return a ^ ze;
         isa_pkg::OP_LUI:   return {imm, 16'h0000};
         default:           return 'x;
      endcase
   endfunction

   // addressed byte or half of a little-endian word, then extension
   function automatic core_pkg::word_t load_model(logic [5:0] op, core_pkg::word_t w,
         logic [1:0] off);
      logic [7:0]  b8;
      logic [15:0] h16;
      b8  = w[8*off +: 8];
      h16 = w[16*off[1] +: 16];
      case (op)
         isa_pkg::OP_LB:  return {{24{b8[7]}}, b8};
         isa_pkg::OP_LBU: return {24'h000000, b8};
         isa_pkg::OP_LH:  return {{16{h16[15]}}, h16};
         isa_pkg::OP_LHU: return {16'h0000, h16};
         default:         return w;
      endcase
   endfunction

   function automatic core_pkg::word_t lane_mask(core_pkg::byte_en_t we);
      core_pkg::word_t m;
      for (int k = 0; k < 4; k++)
         m[8*k +: 8] = {8{we[k]}};
      return m;
   endfunction

   task automatic put_inst(core_pkg::word_t w);
      u_mem.rom[pc_idx] = w;
      pc_idx++;
   endtask

   // full 32-bit constant in two instructions
   task automatic set_reg(logic [4:0] r, core_pkg::word_t value);
      put_inst(itype_word(isa_pkg::OP_LUI, 5'd0, r, value[31:16]));
      put_inst(itype_word(isa_pkg::OP_ORI, r, r, value[15:0]));
   endtask

   task automatic expect_store(string name, int word_slot, core_pkg::byte_en_t we,
         core_pkg::word_t data);
      exp_name.push_back(name);
      exp_addr.push_back(DATA_BASE[31:2] + core_pkg::word_addr_t'(word_slot));
      exp_we.push_back(we);
      exp_data.push_back(data & lane_mask(we));
   endtask

   // each checked result gets a word of its own
   task automatic store_word(string name, logic [4:0] rt, core_pkg::word_t value);
      put_inst(itype_word(isa_pkg::OP_SW, R_BASE, rt, 16'(4 * slot)));
      expect_store(name, slot, 4'hf, value);
      slot++;
   endtask

   // the result register feeds the sw right away, so it stalls
   task automatic rtype_case(string name, logic [5:0] funct);
      core_pkg::word_t a;
      core_pkg::word_t b;
      logic [4:0]      sh;
      a  = rand_bits(32);
      b  = rand_bits(32);
      sh = 5'd0;
      if (funct == isa_pkg::FN_SLL || funct == isa_pkg::FN_SRL || funct == isa_pkg::FN_SRA)
         sh = 5'(rand_bits(5));
      set_reg(R_A, a);
      set_reg(R_B, b);
      put_inst(rtype_word(funct, R_A, R_B, R_D, sh));
      store_word(name, R_D, alu_model(isa_pkg::OP_SPECIAL, funct, a, b, 16'h0000, sh));
   endtask

   task automatic itype_case(string name, logic [5:0] op);
      core_pkg::word_t a;
      logic [15:0]     imm;
      a   = rand_bits(32);
      imm = 16'(rand_bits(16));
      set_reg(R_A, a);
      put_inst(itype_word(op, R_A, R_D, imm));
      store_word(name, R_D, alu_model(op, 6'h00, a, '0, imm, 5'd0));
   endtask

   // sb on every lane, sh on both halves
   task automatic lane_cases();
      core_pkg::word_t src;
      src = rand_bits(32);
      set_reg(R_SRC, src);
      for (int off = 0; off < 4; off++)
      begin
         put_inst(itype_word(isa_pkg::OP_SB, R_BASE, R_SRC, 16'(4 * slot + off)));
         expect_store($sformatf("sb_off%0d", off), slot, 4'b0001 << off,
                      {24'h000000, src[7:0]} << (8 * off));
         slot++;
      end
      for (int off = 0; off < 4; off += 2)
      begin
         put_inst(itype_word(isa_pkg::OP_SH, R_BASE, R_SRC, 16'(4 * slot + off)));
         expect_store($sformatf("sh_off%0d", off), slot, 4'b0011 << off,
                      {16'h0000, src[15:0]} << (8 * off));
         slot++;
      end
   endtask

   task automatic load_case(string name, logic [5:0] op, int src_slot, int off,
         core_pkg::word_t known);
      put_inst(itype_word(op, R_BASE, R_LD, 16'(4 * src_slot + off)));
      store_word($sformatf("%s_off%0d", name, off), R_LD, load_model(op, known, 2'(off)));
   endtask

   // sign bits differ per byte and per half of this word
   task automatic load_cases();
      core_pkg::word_t known;
      int              src_slot;
      known    = 32'h80f7_7f85;
      src_slot = slot;
      set_reg(R_SRC, known);
      store_word("load_src", R_SRC, known);
      for (int off = 0; off < 4; off++)
      begin
         load_case("lb", isa_pkg::OP_LB, src_slot, off, known);
         load_case("lbu", isa_pkg::OP_LBU, src_slot, off, known);
      end
      for (int off = 0; off < 4; off += 2)
      begin
         load_case("lh", isa_pkg::OP_LH, src_slot, off, known);
         load_case("lhu", isa_pkg::OP_LHU, src_slot, off, known);
      end
      load_case("lw", isa_pkg::OP_LW, src_slot, 0, known);
   endtask

   task automatic write_program();
      // an all-zero word is sll $0,$0,0
      for (int i = 0; i < ROM_DEPTH; i++)
         u_mem.rom[i] = '0;
      pc_idx = 0;
      slot   = 0;
      put_inst(itype_word(isa_pkg::OP_LUI, 5'd0, R_BASE, DATA_BASE[31:16]));
      rtype_case("addu", isa_pkg::FN_ADDU);
      rtype_case("subu", isa_pkg::FN_SUBU);
      rtype_case("and", isa_pkg::FN_AND);
      rtype_case("or", isa_pkg::FN_OR);
      rtype_case("xor", isa_pkg::FN_XOR);
      rtype_case("nor", isa_pkg::FN_NOR);
      rtype_case("slt", isa_pkg::FN_SLT);
      rtype_case("sltu", isa_pkg::FN_SLTU);
      rtype_case("sll", isa_pkg::FN_SLL);
      rtype_case("srl", isa_pkg::FN_SRL);
      rtype_case("sra", isa_pkg::FN_SRA);
      rtype_case("sllv", isa_pkg::FN_SLLV);
      rtype_case("srlv", isa_pkg::FN_SRLV);
      rtype_case("srav", isa_pkg::FN_SRAV);
      itype_case("addiu", isa_pkg::OP_ADDIU);
      itype_case("andi", isa_pkg::OP_ANDI);
      itype_case("ori", isa_pkg::OP_ORI);
      itype_case("xori", isa_pkg::OP_XORI);
      itype_case("slti", isa_pkg::OP_SLTI);
      itype_case("sltiu", isa_pkg::OP_SLTIU);
      itype_case("lui", isa_pkg::OP_LUI);
      lane_cases();
      load_cases();
      put_inst(rtype_word(isa_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
   endtask

   task automatic check_idle(string name);
      checks++;
      assert (halted === 1'b0 && mem_we === '0)
      else
      begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, 5'h00, {halted, mem_we});
      end
   endtask

   // every store is matched against the next expected one
   always @(posedge clk)
   begin
      string           name;
      core_pkg::word_t data;
      if (rst_b && mem_we != '0)
      begin
         checks++;
         assert (exp_we.size() > 0)
         else
         begin
            errors++;
            $display("store to word %h with enables %b was not expected", mem_addr, mem_we);
         end
         if (exp_we.size() > 0)
         begin
            name = exp_name.pop_front();
            data = exp_data.pop_front();
            assert (mem_addr === exp_addr[0])
            else
            begin
               errors++;
               $display("[FAIL] %s addr: expected %h, actual %h", name, exp_addr[0], mem_addr);
            end
            assert (mem_we === exp_we[0])
            else
            begin
               errors++;
               $display("[FAIL] %s we: expected %b, actual %b", name, exp_we[0], mem_we);
            end
            // only the enabled lanes carry data
            assert ((mem_wdata & lane_mask(exp_we[0])) === data)
            else
            begin
               errors++;
               $display("[FAIL] %s data: expected %h, actual %h", name, data,
                        mem_wdata & lane_mask(exp_we[0]));
            end
            void'(exp_addr.pop_front());
            void'(exp_we.pop_front());
         end
      end
   end

   // once halted, nothing moves
   always @(posedge clk)
   begin
      if (rst_b)
      begin
         if (halt_seen)
         begin
            checks++;
            assert (halted === 1'b1 && mem_we === '0 && inst_addr === halt_iaddr)
            else
            begin
               errors++;
               $display("[FAIL] halt_hold: expected %h, actual %h",
                        {1'b1, 4'h0, halt_iaddr}, {halted, mem_we, inst_addr});
            end
         end
         else if (halted === 1'b1)
         begin
            halt_seen  = 1'b1;
            halt_iaddr = inst_addr;
         end
      end
   end

   initial
   begin
      int cyc;
      rst_b = 1'b0;
      lfsr  = 16'd9586;
      write_program();
      // three cycles in reset
      for (int i = 0; i < 3; i++)
      begin
         @(negedge clk);
         check_idle("in_reset");
      end
      rst_b = 1'b1;
      checks++;
      assert (inst_addr === TEXT_START[31:2])
      else
      begin
         errors++;
         $display("[FAIL] first_fetch: expected %h, actual %h", TEXT_START[31:2], inst_addr);
      end
      // first clock out of reset still moves only bubbles
      @(negedge clk);
      check_idle("after_reset");
      cyc = 0;
      while (halted !== 1'b1 && cyc < MAX_CYCLES)
      begin
         @(negedge clk);
         cyc++;
      end
      if (halted !== 1'b1)
      begin
         errors++;
         $display("halted did not rise within %0d cycles", MAX_CYCLES);
      end
      else
      begin
         // watch the halted state for a while
         for (int i = 0; i < 8; i++)
            @(negedge clk);
         checks++;
         assert (exp_we.size() == 0)
         else
         begin
            errors++;
            $display("%0d expected stores never reached memory", exp_we.size());
         end
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/alu.sv
rtl/mem_align.sv
rtl/mips_core.sv
tests/tb_mem_model.sv
tests/tb_mips_core.sv
